// File: axi_burst_addr.sv
`timescale 1ns/1ps
// beat address generator for FIXED, INCR and WRAP bursts, loaded at the address handshake
module axi_burst_addr (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic                            load,       // address handshake
  input  logic                            advance,    // beat accepted
  input  logic [axi_mem_pkg::ADDR_W-1:0]  start_addr,
  input  logic [axi_mem_pkg::LEN_W-1:0]   len,
  input  logic [axi_mem_pkg::SIZE_W-1:0]  size,
  input  axi_mem_pkg::burst_t             burst,
  output logic [axi_mem_pkg::ADDR_W-1:0]  addr
);
  import axi_mem_pkg::*;

  logic [LEN_W-1:0]  len_q;
  logic [SIZE_W-1:0] size_q;
  burst_t            burst_q;

  logic [ADDR_W-1:0] step;
  logic [ADDR_W-1:0] aligned;
  logic [ADDR_W-1:0] incr_addr;
  logic [ADDR_W-1:0] wrap_mask;
  logic [ADDR_W-1:0] next_addr;

  assign step      = ADDR_W'(1) << size_q;            // bytes per beat
  assign aligned   = addr & ~(step - ADDR_W'(1));     // first beat may be unaligned
  assign incr_addr = aligned + step;

  // window of (len+1) beats, its size is always a power of two for legal wraps
  assign wrap_mask = ((ADDR_W'(len_q) + ADDR_W'(1)) << size_q) - ADDR_W'(1);

  always_comb begin
    case (burst_q)
      BURST_FIXED: next_addr = addr;
      BURST_WRAP:  next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:     next_addr = incr_addr;
    endcase
  end

  // burst fields, kept for the whole burst
  always_ff @(posedge clk) begin
    if (load) begin
      len_q   <= len;
      size_q  <= size;
      burst_q <= burst;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      addr <= '0;
    end else if (load) begin
      addr <= start_addr;                             // valid in the next cycle
    end else if (advance) begin
      addr <= next_addr;
    end
  end

endmodule

// File: axi_byte_mem.sv
`timescale 1ns/1ps
// word memory with a byte-strobed write port and a combinational read port, addressed in bytes
module axi_byte_mem #(
  parameter int MEM_BYTES = 128                       // multiple of 4
) (
  input  logic                            clk,
  input  logic                            we,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  waddr,
  input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
  input  logic [axi_mem_pkg::STRB_W-1:0]  wstrb,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  raddr,
  output logic [axi_mem_pkg::DATA_W-1:0]  rdata
);
  import axi_mem_pkg::*;

  localparam int DEPTH = MEM_BYTES / 4;
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];                     // contents undefined until written

  logic [IDX_W-1:0] widx;
  logic [IDX_W-1:0] ridx;

  // word index sits above the two lane bits, folded onto the depth
  assign widx = IDX_W'(waddr[ADDR_W-1:2] % DEPTH);
  assign ridx = IDX_W'(raddr[ADDR_W-1:2] % DEPTH);

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wstrb[i]) begin
          mem[widx][8*i +: 8] <= wdata[8*i +: 8];     // lane i holds byte addr mod 4 == i
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////
  // a read in the same cycle as a write to that word sees the old word
  assign rdata = mem[ridx];

endmodule

// File: axi_mem_pkg.sv
// shared bus widths, burst and response encodings and the response decode for the AXI memory slave
package axi_mem_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////
  parameter int ADDR_W = 32;                  // byte address
  parameter int DATA_W = 32;                  // one word per beat
  parameter int STRB_W = DATA_W / 8;          // byte lanes
  parameter int ID_W   = 4;
  parameter int LEN_W  = 4;                   // AXI3 length field of 1 to 16 beats
  parameter int SIZE_W = 3;

  parameter logic [SIZE_W-1:0] MAX_SIZE = 3'd2; // 4 bytes fill the data bus

  //////////////////////////////////////////////////
  // channel encodings
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2                        // 3 is reserved and stepped as INCR
  } burst_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_t;

  // response for a whole burst judged once from its start fields
  // an oversized transfer is a slave error even when the address also misses
  function automatic resp_t decode_resp(input logic [ADDR_W-1:0] addr,
                                        input logic [SIZE_W-1:0] size,
                                        input int unsigned       mem_bytes);
    resp_t resp;
    resp = RESP_OKAY;
    if (size > MAX_SIZE) begin
      resp = RESP_SLVERR;
    end else if (addr >= ADDR_W'(mem_bytes)) begin
      resp = RESP_DECERR;                     // outside the memory
    end
    return resp;
  endfunction

endpackage

// File: axi_mem_slave.f
axi_mem_pkg.sv
axi_burst_addr.sv
axi_byte_mem.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
axi_mem_slave.sv
axi_mem_slave_properties.sv
tb_axi_mem_slave.sv

// File: axi_mem_slave.sv
`timescale 1ns/1ps
// top of the AXI3 memory slave; joins the write control, read control and byte memory
module axi_mem_slave #(
  parameter int MEM_BYTES = 128                       // multiple of 4
) (
  input  logic                            clk,
  input  logic                            resetn,
  // write address
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [axi_mem_pkg::ID_W-1:0]    awid,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  awaddr,
  input  logic [axi_mem_pkg::LEN_W-1:0]   awlen,
  input  logic [axi_mem_pkg::SIZE_W-1:0]  awsize,
  input  axi_mem_pkg::burst_t             awburst,
  // write data
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
  input  logic [axi_mem_pkg::STRB_W-1:0]  wstrb,
  input  logic                            wlast,      // burst end comes from awlen
  // write response
  output logic                            bvalid,
  input  logic                            bready,
  output logic [axi_mem_pkg::ID_W-1:0]    bid,
  output axi_mem_pkg::resp_t              bresp,
  // read address
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [axi_mem_pkg::ID_W-1:0]    arid,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  araddr,
  input  logic [axi_mem_pkg::LEN_W-1:0]   arlen,
  input  logic [axi_mem_pkg::SIZE_W-1:0]  arsize,
  input  axi_mem_pkg::burst_t             arburst,
  // read data
  output logic                            rvalid,
  input  logic                            rready,
  output logic [axi_mem_pkg::ID_W-1:0]    rid,
  output logic [axi_mem_pkg::DATA_W-1:0]  rdata,
  output axi_mem_pkg::resp_t              rresp,
  output logic                            rlast
);
  import axi_mem_pkg::*;

  logic              mem_we;
  logic [ADDR_W-1:0] mem_waddr;
  logic [DATA_W-1:0] mem_wdata;
  logic [STRB_W-1:0] mem_wstrb;
  logic [ADDR_W-1:0] mem_raddr;
  logic [DATA_W-1:0] mem_rdata;

  axi_write_ctrl #(.MEM_BYTES(MEM_BYTES)) u_write_ctrl (
    .clk (clk), .resetn (resetn),
    .awvalid (awvalid), .awready (awready), .awid (awid), .awaddr (awaddr),
    .awlen (awlen), .awsize (awsize), .awburst (awburst),
    .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
    .bvalid (bvalid), .bready (bready), .bid (bid), .bresp (bresp),
    .mem_we (mem_we), .mem_waddr (mem_waddr), .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb)
  );

  axi_read_ctrl #(.MEM_BYTES(MEM_BYTES)) u_read_ctrl (
    .clk (clk), .resetn (resetn),
    .arvalid (arvalid), .arready (arready), .arid (arid), .araddr (araddr),
    .arlen (arlen), .arsize (arsize), .arburst (arburst),
    .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata),
    .rresp (rresp), .rlast (rlast),
    .mem_raddr (mem_raddr), .mem_rdata (mem_rdata)
  );

  axi_byte_mem #(.MEM_BYTES(MEM_BYTES)) u_mem (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .wstrb (mem_wstrb),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

// File: axi_mem_slave_properties.sv
`timescale 1ns/1ps
// concurrent protocol checks for the AXI memory slave, bound into every axi_mem_slave instance
module axi_mem_slave_properties (
  input logic                            clk,
  input logic                            resetn,
  input logic                            awvalid,
  input logic                            awready,
  input logic [axi_mem_pkg::ID_W-1:0]    awid,
  input logic [axi_mem_pkg::LEN_W-1:0]   awlen,
  input logic                            wvalid,
  input logic                            wready,
  input logic                            bvalid,
  input logic                            bready,
  input logic [axi_mem_pkg::ID_W-1:0]    bid,
  input logic [1:0]                      bresp,
  input logic                            arvalid,
  input logic                            arready,
  input logic [axi_mem_pkg::ID_W-1:0]    arid,
  input logic [axi_mem_pkg::LEN_W-1:0]   arlen,
  input logic                            rvalid,
  input logic                            rready,
  input logic [axi_mem_pkg::ID_W-1:0]    rid,
  input logic [axi_mem_pkg::DATA_W-1:0]  rdata,
  input logic [1:0]                      rresp,
  input logic                            rlast
);
  import axi_mem_pkg::*;

  int unsigned      fail_count = 0;
  logic [LEN_W-1:0] w_len;
  logic [LEN_W-1:0] r_len;
  logic [ID_W-1:0]  w_id;
  logic [ID_W-1:0]  r_id;
  logic [LEN_W:0]   w_cnt;                          // accepted W beats of the burst
  logic [LEN_W:0]   r_cnt;                          // accepted R beats of the burst

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      w_len <= '0;
      r_len <= '0;
      w_id  <= '0;
      r_id  <= '0;
      w_cnt <= '0;
      r_cnt <= '0;
    end else begin
      if (awvalid && awready) begin
        w_len <= awlen;
        w_id  <= awid;
        w_cnt <= '0;
      end else if (wvalid && wready) begin
        w_cnt <= w_cnt + 1'b1;
      end
      if (arvalid && arready) begin
        r_len <= arlen;
        r_id  <= arid;
        r_cnt <= '0;
      end else if (rvalid && rready) begin
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // reset and handshake
  //////////////////////////////////////////////////
  reset_quiet: assert property (@(posedge clk)
    !resetn |-> !(awready || wready || bvalid || arready || rvalid || rlast))
    else begin fail_count++; $error("control output high during reset"); end

  ready_after_reset: assert property (@(posedge clk) $rose(resetn) |=> awready && arready)
    else begin fail_count++; $error("awready or arready low after reset release"); end

  r_hold: assert property (@(posedge clk) disable iff (!resetn)
    rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rresp)
                          && $stable(rlast))
    else begin fail_count++; $error("R channel changed while stalled"); end

  b_hold: assert property (@(posedge clk) disable iff (!resetn)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
    else begin fail_count++; $error("B channel changed while stalled"); end

  //////////////////////////////////////////////////
  // burst length and IDs
  //////////////////////////////////////////////////
  rlast_on_last: assert property (@(posedge clk) disable iff (!resetn)
    rvalid |-> (rlast == (r_cnt == {1'b0, r_len})))
    else begin fail_count++; $error("rlast not on the last read beat"); end

  wready_drops: assert property (@(posedge clk) disable iff (!resetn)
    wvalid && wready && (w_cnt == {1'b0, w_len}) |=> !wready)
    else begin fail_count++; $error("wready still high after the last write beat"); end

  b_after_beats: assert property (@(posedge clk) disable iff (!resetn)
    bvalid |-> (w_cnt == {1'b0, w_len} + 1'b1))
    else begin fail_count++; $error("write response before all beats were taken"); end

  rid_match: assert property (@(posedge clk) disable iff (!resetn) rvalid |-> rid == r_id)
    else begin fail_count++; $error("rid differs from the captured arid"); end

  bid_match: assert property (@(posedge clk) disable iff (!resetn) bvalid |-> bid == w_id)
    else begin fail_count++; $error("bid differs from the captured awid"); end

endmodule

bind axi_mem_slave axi_mem_slave_properties u_props (
  .clk (clk), .resetn (resetn),
  .awvalid (awvalid), .awready (awready), .awid (awid), .awlen (awlen),
  .wvalid (wvalid), .wready (wready),
  .bvalid (bvalid), .bready (bready), .bid (bid), .bresp (bresp),
  .arvalid (arvalid), .arready (arready), .arid (arid), .arlen (arlen),
  .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata),
  .rresp (rresp), .rlast (rlast)
);

// File: axi_read_ctrl.sv
`timescale 1ns/1ps
// read side of the slave; takes one AR burst and returns its beats on R back to back
module axi_read_ctrl #(
  parameter int MEM_BYTES = 128
) (
  input  logic                            clk,
  input  logic                            resetn,
  // read address
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [axi_mem_pkg::ID_W-1:0]    arid,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  araddr,
  input  logic [axi_mem_pkg::LEN_W-1:0]   arlen,
  input  logic [axi_mem_pkg::SIZE_W-1:0]  arsize,
  input  axi_mem_pkg::burst_t             arburst,
  // read data
  output logic                            rvalid,
  input  logic                            rready,
  output logic [axi_mem_pkg::ID_W-1:0]    rid,
  output logic [axi_mem_pkg::DATA_W-1:0]  rdata,
  output axi_mem_pkg::resp_t              rresp,
  output logic                            rlast,
  // memory read port
  output logic [axi_mem_pkg::ADDR_W-1:0]  mem_raddr,
  input  logic [axi_mem_pkg::DATA_W-1:0]  mem_rdata
);
  import axi_mem_pkg::*;

  typedef enum logic {
    R_IDLE,
    R_BEAT
  } rstate_t;

  rstate_t           state;
  rstate_t           state_nxt;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat_cnt;
  logic              fresh;                           // first cycle a beat is shown
  logic [DATA_W-1:0] held_data;
  logic [DATA_W-1:0] beat_data;
  logic              ar_hs;
  logic              r_hs;
  logic              last_beat;

  assign ar_hs     = arvalid & arready;
  assign r_hs      = rvalid & rready;
  assign last_beat = (beat_cnt == len_q);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      R_IDLE:  if (ar_hs) state_nxt = R_BEAT;
      R_BEAT:  if (r_hs && last_beat) state_nxt = R_IDLE;
      default: state_nxt = R_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= R_IDLE;
      arready  <= 1'b0;
      beat_cnt <= '0;
      fresh    <= 1'b0;
    end else begin
      state    <= state_nxt;
      arready  <= (state_nxt == R_IDLE);
      fresh    <= (state_nxt == R_BEAT) && (ar_hs || r_hs); // next beat, no gap
      if (ar_hs) begin
        beat_cnt <= '0;
      end else if (r_hs) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      len_q <= arlen;
      rid   <= arid;
      rresp <= decode_resp(araddr, arsize, MEM_BYTES);
    end
    held_data <= rdata;                               // freezes the beat while stalled
  end

  //////////////////////////////////////////////////
  // R payload
  //////////////////////////////////////////////////
  axi_burst_addr u_addr (
    .clk        (clk),
    .resetn     (resetn),
    .load       (ar_hs),
    .advance    (r_hs),
    .start_addr (araddr),
    .len        (arlen),
    .size       (arsize),
    .burst      (arburst),
    .addr       (mem_raddr)
  );

  assign beat_data = (rresp == RESP_OKAY) ? mem_rdata : '0; // zero on error
  // a write landing during a stall must not disturb the beat on the bus
  assign rdata     = fresh ? beat_data : held_data;
  assign rvalid    = (state == R_BEAT);
  assign rlast     = rvalid && last_beat;

endmodule

// File: axi_write_ctrl.sv
`timescale 1ns/1ps
// write side of the slave; takes one AW burst, writes its W beats to memory and returns B
module axi_write_ctrl #(
  parameter int MEM_BYTES = 128
) (
  input  logic                            clk,
  input  logic                            resetn,
  // write address
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [axi_mem_pkg::ID_W-1:0]    awid,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  awaddr,
  input  logic [axi_mem_pkg::LEN_W-1:0]   awlen,
  input  logic [axi_mem_pkg::SIZE_W-1:0]  awsize,
  input  axi_mem_pkg::burst_t             awburst,
  // write data
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
  input  logic [axi_mem_pkg::STRB_W-1:0]  wstrb,
  // write response
  output logic                            bvalid,
  input  logic                            bready,
  output logic [axi_mem_pkg::ID_W-1:0]    bid,
  output axi_mem_pkg::resp_t              bresp,
  // memory write port
  output logic                            mem_we,
  output logic [axi_mem_pkg::ADDR_W-1:0]  mem_waddr,
  output logic [axi_mem_pkg::DATA_W-1:0]  mem_wdata,
  output logic [axi_mem_pkg::STRB_W-1:0]  mem_wstrb
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wstate_t;

  wstate_t          state;
  wstate_t          state_nxt;
  logic [LEN_W-1:0] len_q;
  logic [LEN_W-1:0] beat_cnt;
  logic             aw_hs;
  logic             w_hs;
  logic             b_hs;
  logic             last_beat;

  assign aw_hs     = awvalid & awready;
  assign w_hs      = wvalid & wready;
  assign b_hs      = bvalid & bready;
  assign last_beat = (beat_cnt == len_q);             // beat count ends the burst

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      W_IDLE:  if (aw_hs) state_nxt = W_DATA;
      W_DATA:  if (w_hs && last_beat) state_nxt = W_RESP;
      W_RESP:  if (b_hs) state_nxt = W_IDLE;
      default: state_nxt = W_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= W_IDLE;
      awready  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      state    <= state_nxt;
      awready  <= (state_nxt == W_IDLE);              // back up the cycle after B
      if (aw_hs) begin
        beat_cnt <= '0;
      end else if (w_hs) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // burst fields, response judged once at AW
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      len_q <= awlen;
      bid   <= awid;
      bresp <= decode_resp(awaddr, awsize, MEM_BYTES);
    end
  end

  assign wready = (state == W_DATA);
  assign bvalid = (state == W_RESP);

  //////////////////////////////////////////////////
  // memory write port
  //////////////////////////////////////////////////
  axi_burst_addr u_addr (
    .clk        (clk),
    .resetn     (resetn),
    .load       (aw_hs),
    .advance    (w_hs),
    .start_addr (awaddr),
    .len        (awlen),
    .size       (awsize),
    .burst      (awburst),
    .addr       (mem_waddr)
  );

  assign mem_we    = w_hs && (bresp == RESP_OKAY);    // error bursts drain without writing
  assign mem_wdata = wdata;
  assign mem_wstrb = wstrb;

endmodule

// File: run.sh
#!/bin/sh
# builds the AXI memory slave testbench with Verilator and runs it; exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_axi_mem_slave -f axi_mem_slave.f -o tb_axi_mem_slave &&
./obj_dir/tb_axi_mem_slave +verilator+error+limit+1000 ||
{ echo "simulation did not pass"; exit 1; }

// File: tb_axi_mem_slave.sv
`timescale 1ns/1ps
// testbench for the AXI memory slave; directed bursts under random back-pressure, checked against a byte model
module tb_axi_mem_slave;
  import axi_mem_pkg::*;

  localparam int MEM_BYTES = 64;                    // 16 words
  localparam int TIMEOUT   = 200;                   // cycles per wait

  logic              clk;
  logic              resetn;
  logic              awvalid;
  logic              awready;
  logic [ID_W-1:0]   awid;
  logic [ADDR_W-1:0] awaddr;
  logic [LEN_W-1:0]  awlen;
  logic [SIZE_W-1:0] awsize;
  burst_t            awburst;
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wlast;
  logic              bvalid;
  logic              bready;
  logic [ID_W-1:0]   bid;
  resp_t             bresp;
  logic              arvalid;
  logic              arready;
  logic [ID_W-1:0]   arid;
  logic [ADDR_W-1:0] araddr;
  logic [LEN_W-1:0]  arlen;
  logic [SIZE_W-1:0] arsize;
  burst_t            arburst;
  logic              rvalid;
  logic              rready;
  logic [ID_W-1:0]   rid;
  logic [DATA_W-1:0] rdata;
  resp_t             rresp;
  logic              rlast;

  logic [7:0]  model [MEM_BYTES];                   // expected memory, one entry per byte
  logic [31:0] lfsr_state = 32'd82814;

  axi_mem_slave #(.MEM_BYTES(MEM_BYTES)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    fail_stop($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", test, exp, act));
  endtask

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      v          = {v[30:0], lfsr_state[31]};
      lfsr_state = {lfsr_state[30:0], fb};
    end
    return v;
  endfunction

  // address of beat n, straight from the AXI stepping rules
  function automatic logic [31:0] beat_addr(input logic [31:0] start, input int len,
                                            input int size, input burst_t burst, input int n);
    logic [31:0] bytes;
    logic [31:0] window;
    logic [31:0] lin;
    logic [31:0] base;
    bytes  = 32'd1 << size;
    window = 32'(len + 1) * bytes;
    lin    = (start & ~(bytes - 1)) + 32'(n) * bytes;
    base   = start & ~(window - 1);
    if (n == 0 || burst == BURST_FIXED) return start;
    if (burst == BURST_WRAP) return base + ((lin - base) % window);
    return lin;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    int base;
    base = int'((a % MEM_BYTES) & ~32'd3);
    return {model[base + 3], model[base + 2], model[base + 1], model[base]};
  endfunction

  //////////////////////////////////////////////////
  // bursts
  //////////////////////////////////////////////////
  task automatic write_burst(input string name, input logic [ID_W-1:0] id,
                             input logic [31:0] addr, input int len, input int size,
                             input burst_t burst, input bit full_strb, input resp_t exp_resp);
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    int                base;
    int                cnt;
    @(posedge clk);
    awvalid <= 1'b1;
    awid    <= id;
    awaddr  <= addr;
    awlen   <= LEN_W'(len);
    awsize  <= SIZE_W'(size);
    awburst <= burst;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) fail_stop({name, ": write address never accepted"});
    end while (!awready);
    @(posedge clk);
    awvalid <= 1'b0;
    for (int n = 0; n <= len; n++) begin
      data = lfsr_bits(32);
      strb = full_strb ? '1 : STRB_W'(lfsr_bits(STRB_W));
      wvalid <= 1'b1;
      wdata  <= data;
      wstrb  <= strb;
      wlast  <= (n == len);
      cnt = 0;
      do begin
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) fail_stop({name, ": write beat never accepted"});
      end while (!wready);
      @(posedge clk);                               // beat taken here
      if (exp_resp == RESP_OKAY) begin
        base = int'((beat_addr(addr, len, size, burst, n) % MEM_BYTES) & ~32'd3);
        for (int i = 0; i < STRB_W; i++) begin
          if (strb[i]) model[base + i] = data[8*i +: 8];
        end
      end
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    cnt = 0;
    do begin
      bready <= (lfsr_bits(1) != 0);                // random stall on B
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) fail_stop({name, ": write response never completed"});
      if (!(bvalid && bready)) @(posedge clk);
    end while (!(bvalid && bready));
    assert (bresp == exp_resp) else report_mismatch({name, " bresp"}, 32'(exp_resp), 32'(bresp));
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_burst(input string name, input logic [ID_W-1:0] id,
                            input logic [31:0] addr, input int len, input int size,
                            input burst_t burst, input resp_t exp_resp);
    logic [DATA_W-1:0] exp;
    int                cnt;
    @(posedge clk);
    arvalid <= 1'b1;
    arid    <= id;
    araddr  <= addr;
    arlen   <= LEN_W'(len);
    arsize  <= SIZE_W'(size);
    arburst <= burst;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) fail_stop({name, ": read address never accepted"});
    end while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    for (int n = 0; n <= len; n++) begin
      cnt = 0;
      do begin
        rready <= (lfsr_bits(1) != 0);              // random stall on R
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) fail_stop($sformatf("%s: read beat %0d never came", name, n));
        if (!(rvalid && rready)) @(posedge clk);
      end while (!(rvalid && rready));
      exp = (exp_resp == RESP_OKAY) ? model_word(beat_addr(addr, len, size, burst, n)) : '0;
      assert (rdata == exp) else report_mismatch($sformatf("%s beat %0d", name, n), exp, rdata);
      assert (rresp == exp_resp)
        else report_mismatch($sformatf("%s rresp %0d", name, n), 32'(exp_resp), 32'(rresp));
      @(posedge clk);
    end
    rready <= 1'b0;
  endtask

  always @(negedge clk) begin
    if (u_dut.u_props.fail_count != 0) fail_stop("a protocol assertion on the DUT failed");
  end

  initial begin
    awvalid <= 1'b0;
    awid    <= '0;
    awaddr  <= '0;
    awlen   <= '0;
    awsize  <= '0;
    awburst <= BURST_INCR;
    wvalid  <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wlast   <= 1'b0;
    bready  <= 1'b0;
    arvalid <= 1'b0;
    arid    <= '0;
    araddr  <= '0;
    arlen   <= '0;
    arsize  <= '0;
    arburst <= BURST_INCR;
    rready  <= 1'b0;
    resetn  <= 1'b0;
    repeat (3) @(posedge clk);
    resetn  <= 1'b1;
    // whole memory first, then partial strobes and narrow reads
    write_burst("fill_wr", 4'h1, 32'h00, 15, 2, BURST_INCR, 1'b1, RESP_OKAY);
    read_burst("fill_rd", 4'h2, 32'h00, 15, 2, BURST_INCR, RESP_OKAY);
    write_burst("strb_wr", 4'h3, 32'h08, 3, 2, BURST_INCR, 1'b0, RESP_OKAY);
    read_burst("strb_rd", 4'h4, 32'h00, 7, 2, BURST_INCR, RESP_OKAY);
    read_burst("incr_size1", 4'h5, 32'h05, 7, 0, BURST_INCR, RESP_OKAY);
    read_burst("incr_size2", 4'h6, 32'h22, 5, 1, BURST_INCR, RESP_OKAY);
    write_burst("wrap_wr", 4'h7, 32'h18, 3, 2, BURST_WRAP, 1'b1, RESP_OKAY);
    read_burst("wrap_rd", 4'h8, 32'h14, 3, 2, BURST_WRAP, RESP_OKAY);
    write_burst("fixed_wr", 4'h9, 32'h30, 3, 2, BURST_FIXED, 1'b1, RESP_OKAY);
    read_burst("fixed_rd", 4'hA, 32'h30, 3, 2, BURST_FIXED, RESP_OKAY);
    // error bursts leave memory alone
    write_burst("decerr_wr", 4'hB, 32'(MEM_BYTES), 1, 2, BURST_INCR, 1'b1, RESP_DECERR);
    read_burst("decerr_rd", 4'hC, 32'(MEM_BYTES), 2, 2, BURST_INCR, RESP_DECERR);
    write_burst("slverr_wr", 4'hD, 32'h20, 1, 3, BURST_INCR, 1'b1, RESP_SLVERR);
    read_burst("slverr_rd", 4'hE, 32'h20, 1, 3, BURST_INCR, RESP_SLVERR);
    read_burst("after_err_rd", 4'hF, 32'h00, 15, 2, BURST_INCR, RESP_OKAY);
    fork
      write_burst("both_wr", 4'h1, 32'h00, 7, 2, BURST_INCR, 1'b0, RESP_OKAY);
      read_burst("both_rd", 4'h2, 32'h20, 7, 2, BURST_INCR, RESP_OKAY);
    join
    read_burst("final_rd", 4'h3, 32'h00, 15, 2, BURST_INCR, RESP_OKAY);
    repeat (4) @(posedge clk);
    if (u_dut.u_props.fail_count != 0) begin
      fail_stop("a protocol assertion on the DUT failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
